// ==== common/dbg_map_pkg.sv ====
// Address map of the hart-facing debug memory and the hart bus types.
// Imported by the bus decoder, the status registers and the command generator.
`default_nettype none

package dbg_map_pkg;

    // only the low address bits are decoded
    localparam int unsigned DBG_ADDR_BITS = 12;

    // hart status write targets
    localparam logic [DBG_ADDR_BITS-1:0] HALTED_ADDR    = 12'h100;
    localparam logic [DBG_ADDR_BITS-1:0] GOING_ADDR     = 12'h104;
    localparam logic [DBG_ADDR_BITS-1:0] RESUMING_ADDR  = 12'h108;
    localparam logic [DBG_ADDR_BITS-1:0] EXCEPTION_ADDR = 12'h10C;

    localparam logic [DBG_ADDR_BITS-1:0] WHERETO_ADDR   = 12'h300;
    localparam logic [DBG_ADDR_BITS-1:0] ABST_CMD_BASE  = 12'h330;
    localparam logic [DBG_ADDR_BITS-1:0] PROGBUF_BASE   = 12'h358;
    localparam logic [DBG_ADDR_BITS-1:0] DATA_BASE      = 12'h380;
    // harts poll here for go and resume
    localparam logic [DBG_ADDR_BITS-1:0] FLAGS_ADDR     = 12'h400;

    localparam int unsigned ABST_CMD_WORDS = 10;
    localparam int unsigned DATA_WORDS     = 5;

    // hart bus request, grant and response are separate ports
    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
    } hart_req_t;

    // one-cycle write events decoded from the hart bus
    typedef struct packed {
        logic halted;
        logic going;
        logic resuming;
        logic exception;
    } hart_evt_t;

endpackage

`default_nettype wire

// ==== common/dbg_cmd_pkg.sv ====
// Abstract command definitions: command word layout, error codes and the
// RV32 instruction encoders used to build the command sequence.
`default_nettype none

package dbg_cmd_pkg;

    typedef struct packed {
        logic [7:0]  cmd_type;
        logic        reserved;
        logic [2:0]  aarsize;
        logic        postincrement;
        logic        postexec;
        logic        transfer;
        logic        write;
        logic [15:0] regno;
    } cmd_t;

    localparam logic [7:0] CMD_ACCESS_REG = 8'h00;

    typedef enum logic [2:0] {
        NONE          = 3'd0,
        NOT_SUPPORTED = 3'd2,
        EXCEPTION     = 3'd3,
        HALT_RESUME   = 3'd4
    } cmd_err_t;

    // ten words fetched by the hart, word 0 in the low bits
    typedef logic [9:0][31:0] cmd_words_t;

    localparam logic [31:0] INSN_ILLEGAL = 32'h0000_0000;
    localparam logic [31:0] INSN_NOP     = 32'h0000_0013;
    localparam logic [31:0] INSN_EBREAK  = 32'h0010_0073;

    localparam logic [4:0] REG_S0 = 5'd8;
    localparam logic [4:0] REG_A0 = 5'd10;

    localparam logic [11:0] CSR_DSCRATCH0 = 12'h7B2;
    localparam logic [11:0] CSR_DSCRATCH1 = 12'h7B3;

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // upper immediate, bits 31:12 of the offset
    function automatic logic [31:0] auipc(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'h17};
    endfunction

    function automatic logic [31:0] slli(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [5:0] shamt);
        return {6'b0, shamt, rs1, 3'h1, rd, 7'h13};
    endfunction

    function automatic logic [31:0] srli(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [5:0] shamt);
        return {6'b0, shamt, rs1, 3'h5, rd, 7'h13};
    endfunction

    function automatic logic [31:0] load(input logic [2:0] size, input logic [4:0] dest,
                                         input logic [4:0] base, input logic [11:0] offset);
        return {offset, base, size, dest, 7'h03};
    endfunction

    function automatic logic [31:0] store(input logic [2:0] size, input logic [4:0] src,
                                          input logic [4:0] base, input logic [11:0] offset);
        return {offset[11:5], src, base, size, offset[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] csrw(input logic [11:0] csr, input logic [4:0] rs1);
        return {csr, rs1, 3'h1, 5'h0, 7'h73};
    endfunction

    function automatic logic [31:0] csrr(input logic [11:0] csr, input logic [4:0] dest);
        return {csr, 5'h0, 3'h2, dest, 7'h73};
    endfunction

endpackage

`default_nettype wire

// ==== dbg_cmd/abst_cmd_gen.sv ====
// Builds the ten-word abstract command sequence for access-register commands.
// Purely combinational; the words follow the command word at all times.
`timescale 1ns/1ps
`default_nettype none

module abst_cmd_gen import dbg_map_pkg::*, dbg_cmd_pkg::*; (
    input  cmd_t       cmd_i,
    output cmd_words_t words_o,
    output logic       unsupported_o
);

    logic        is_gpr;
    logic        is_a0;
    logic [11:0] xfer_csr;

    // regno 0x1000 to 0x101f are the GPRs
    assign is_gpr = cmd_i.regno[12];
    assign is_a0  = is_gpr && (cmd_i.regno[4:0] == REG_A0);
    // a0 itself was parked in dscratch1 by word 0
    assign xfer_csr = is_a0 ? CSR_DSCRATCH1 : cmd_i.regno[11:0];

    always_comb begin
        unsupported_o = 1'b0;

        words_o[0] = INSN_ILLEGAL;
        // a0 <- page base of this memory
        words_o[1] = auipc(REG_A0, 20'd0);
        words_o[2] = srli(REG_A0, REG_A0, 6'd12);
        words_o[3] = slli(REG_A0, REG_A0, 6'd12);
        words_o[4] = INSN_NOP;
        words_o[5] = INSN_NOP;
        words_o[6] = INSN_NOP;
        words_o[7] = INSN_NOP;
        // restore a0
        words_o[8] = csrr(CSR_DSCRATCH1, REG_A0);
        words_o[9] = INSN_EBREAK;

        if (cmd_i.cmd_type != CMD_ACCESS_REG || cmd_i.aarsize > 3'd2 ||
            cmd_i.postincrement || cmd_i.regno >= 16'h1020) begin
            // quick access and memory access land here too
            unsupported_o = 1'b1;
            words_o[0]    = INSN_EBREAK;
        end else begin
            words_o[0] = csrw(CSR_DSCRATCH1, REG_A0);

            if (cmd_i.transfer) begin
                if (is_gpr && !is_a0) begin
                    // direct move between the GPR and data0
                    words_o[4] = cmd_i.write ?
                        load(cmd_i.aarsize, cmd_i.regno[4:0], REG_A0, DATA_BASE) :
                        store(cmd_i.aarsize, cmd_i.regno[4:0], REG_A0, DATA_BASE);
                end else begin
                    // s0 as scratch, saved in dscratch0
                    words_o[4] = csrw(CSR_DSCRATCH0, REG_S0);
                    words_o[5] = cmd_i.write ?
                        load(cmd_i.aarsize, REG_S0, REG_A0, DATA_BASE) :
                        csrr(xfer_csr, REG_S0);
                    words_o[6] = cmd_i.write ?
                        csrw(xfer_csr, REG_S0) :
                        store(cmd_i.aarsize, REG_S0, REG_A0, DATA_BASE);
                    words_o[7] = csrr(CSR_DSCRATCH0, REG_S0);
                end
            end

            // fall through into the program buffer
            if (cmd_i.postexec) begin
                words_o[9] = INSN_NOP;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dbg_cmd/cmd_fsm.sv ====
// Command and resume state machine of the debug memory.
// Accepts or rejects debugger commands in the same cycle and drives the
// go and resume flags that the hart polls.
`timescale 1ns/1ps
`default_nettype none

module cmd_fsm import dbg_map_pkg::*, dbg_cmd_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid_i,
    input  logic      unsupported_i,
    input  logic      halted_i,
    input  logic      resuming_i,
    input  logic      resumereq_i,
    input  logic      haltreq_i,
    input  hart_evt_t evt_i,
    output logic      go_o,
    output logic      resume_o,
    output logic      busy_o,
    output logic      err_valid_o,
    output cmd_err_t  err_o
);

    typedef enum logic [3:0] {
        S_IDLE   = 4'b0001,
        S_RESUME = 4'b0010,
        S_GO     = 4'b0100,
        S_EXEC   = 4'b1000
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d     = state_q;
        go_o        = 1'b0;
        resume_o    = 1'b0;
        busy_o      = 1'b1;
        err_valid_o = 1'b0;
        err_o       = NONE;

        case (state_q)
            S_IDLE: begin
                busy_o = 1'b0;
                if (resumereq_i && halted_i && !resuming_i && !haltreq_i) begin
                    state_d = S_RESUME;
                end
                // a command overrides a pending resume request
                if (cmd_valid_i) begin
                    if (!halted_i) begin
                        err_valid_o = 1'b1;
                        err_o       = HALT_RESUME;
                    end else if (unsupported_i) begin
                        err_valid_o = 1'b1;
                        err_o       = NOT_SUPPORTED;
                    end else begin
                        state_d = S_GO;
                    end
                end
            end
            S_GO: begin
                go_o = 1'b1;
                if (evt_i.going) begin
                    state_d = S_EXEC;
                end
            end
            // leave once the acknowledge is registered
            S_RESUME: begin
                resume_o = 1'b1;
                if (resuming_i) begin
                    state_d = S_IDLE;
                end
            end
            // hart is back in the park loop
            S_EXEC: begin
                if (evt_i.halted) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase

        if (evt_i.exception) begin
            err_valid_o = 1'b1;
            err_o       = EXCEPTION;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/hart_status.sv ====
// Halted and resume-acknowledge flags of the hart.
// Both are set by hart bus write events; the debugger clears resumeack.
`timescale 1ns/1ps
`default_nettype none

module hart_status import dbg_map_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  hart_evt_t evt_i,
    input  logic      clear_resumeack_i,
    input  logic      ndmreset_i,
    input  logic      haltreq_i,
    output logic      halted_o,
    output logic      resuming_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_o   <= 1'b0;
            resuming_o <= 1'b0;
        end else begin
            // later assignments take priority, the halted write wins
            if (ndmreset_i && !haltreq_i) begin
                halted_o <= 1'b0;
            end
            if (evt_i.resuming) begin
                halted_o <= 1'b0;
            end
            if (evt_i.halted) begin
                halted_o <= 1'b1;
            end

            if (clear_resumeack_i) begin
                resuming_o <= 1'b0;
            end
            if (evt_i.resuming) begin
                resuming_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/hart_bus.sv ====
// Hart bus slave of the debug memory.
// Decodes status writes into events, merges data writes over data_i and
// answers reads one cycle after the request from a registered read word.
`timescale 1ns/1ps
`default_nettype none

module hart_bus import dbg_map_pkg::*, dbg_cmd_pkg::*; #(
    parameter int unsigned PROG_BUF_SIZE = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  hart_req_t        hart_i,
    input  logic [9:0][31:0] progbuf_i,
    input  logic [31:0]      data_i,
    input  cmd_words_t       words_i,
    input  logic             go_i,
    input  logic             resume_i,
    input  logic             busy_i,
    input  cmd_t             cmd_i,
    output hart_evt_t        evt_o,
    output logic [31:0]      data_o,
    output logic             data_valid_o,
    output logic             gnt_o,
    output logic             rvalid_o,
    output logic [31:0]      rdata_o
);

    localparam int unsigned PB_WINDOW = 10;
    localparam int unsigned WA = DBG_ADDR_BITS - 2;

    // jumps from whereto, offsets relative to WHERETO_ADDR
    localparam logic [31:0] JAL_PROGBUF = jal(5'd0, {9'd0, PROGBUF_BASE - WHERETO_ADDR});
    localparam logic [31:0] JAL_ABSTCMD = jal(5'd0, {9'd0, ABST_CMD_BASE - WHERETO_ADDR});

    logic [DBG_ADDR_BITS-1:0] addr;
    logic [WA-1:0]            data_idx;
    logic [WA-1:0]            pb_idx;
    logic [WA-1:0]            ac_idx;
    logic                     aligned;
    logic                     wr;
    logic                     rd;
    logic                     in_data;
    logic                     in_pb;
    logic                     in_ac;
    logic [31:0]              rdata_d;

    assign addr    = hart_i.addr[DBG_ADDR_BITS-1:0];
    assign aligned = (addr[1:0] == 2'b00);
    assign wr      = hart_i.req && hart_i.we;
    assign rd      = hart_i.req && !hart_i.we;

    // word offsets into each window, wrap to large values below the base
    assign data_idx = addr[DBG_ADDR_BITS-1:2] - DATA_BASE[DBG_ADDR_BITS-1:2];
    assign pb_idx   = addr[DBG_ADDR_BITS-1:2] - PROGBUF_BASE[DBG_ADDR_BITS-1:2];
    assign ac_idx   = addr[DBG_ADDR_BITS-1:2] - ABST_CMD_BASE[DBG_ADDR_BITS-1:2];
    assign in_data  = aligned && (data_idx < DATA_WORDS);
    assign in_pb    = aligned && (pb_idx < PB_WINDOW);
    assign in_ac    = aligned && (ac_idx < ABST_CMD_WORDS);

    assign gnt_o = hart_i.req;

    assign evt_o.halted    = wr && (addr == HALTED_ADDR);
    assign evt_o.going     = wr && (addr == GOING_ADDR);
    assign evt_o.resuming  = wr && (addr == RESUMING_ADDR);
    assign evt_o.exception = wr && (addr == EXCEPTION_ADDR);

    // byte merge toward the debugger
    assign data_valid_o = wr && in_data;
    always_comb begin
        data_o = data_i;
        for (int b = 0; b < 4; b++) begin
            if (data_valid_o && hart_i.be[b]) begin
                data_o[8*b +: 8] = hart_i.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        rdata_d = rdata_o;
        if (rd) begin
            if (addr == FLAGS_ADDR) begin
                rdata_d = {30'd0, resume_i, go_i};
            end else if (addr == WHERETO_ADDR) begin
                if (busy_i && cmd_i.cmd_type == CMD_ACCESS_REG) begin
                    rdata_d = cmd_i.postexec ? JAL_PROGBUF : JAL_ABSTCMD;
                end
            end else if (in_data) begin
                rdata_d = data_i;
            end else if (in_pb) begin
                // words past the implemented buffer read as zero
                rdata_d = (pb_idx < PROG_BUF_SIZE) ? progbuf_i[pb_idx[3:0]] : 32'd0;
            end else if (in_ac) begin
                rdata_d = words_i[ac_idx[3:0]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
            rdata_o  <= 32'd0;
        end else begin
            rvalid_o <= hart_i.req;
            rdata_o  <= rdata_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dbg_mem_top.sv ====
// Top level of the hart-facing debug memory.
// Connects the hart bus, the status flags, the command FSM and the
// abstract command generator; PROG_BUF_SIZE is set here.
`timescale 1ns/1ps
`default_nettype none

module dbg_mem_top import dbg_map_pkg::*, dbg_cmd_pkg::*; #(
    parameter int unsigned PROG_BUF_SIZE = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear_resumeack_i,
    input  logic             resumereq_i,
    input  logic             haltreq_i,
    input  logic             ndmreset_i,
    input  logic [9:0][31:0] progbuf_i,
    input  logic [31:0]      data_i,
    input  logic             cmd_valid_i,
    input  cmd_t             cmd_i,
    input  hart_req_t        hart_i,
    output logic             halted_o,
    output logic             resumeack_o,
    output logic [31:0]      data_o,
    output logic             data_valid_o,
    output logic             cmderror_valid_o,
    output cmd_err_t         cmderror_o,
    output logic             cmdbusy_o,
    output logic             gnt_o,
    output logic             rvalid_o,
    output logic [31:0]      rdata_o
);

    hart_evt_t  evt;
    cmd_words_t words;
    logic       unsupported;
    logic       go;
    logic       resume;

    hart_status u_hart_status (
        .clk               (clk),
        .rst_n             (rst_n),
        .evt_i             (evt),
        .clear_resumeack_i (clear_resumeack_i),
        .ndmreset_i        (ndmreset_i),
        .haltreq_i         (haltreq_i),
        .halted_o          (halted_o),
        .resuming_o        (resumeack_o)
    );

    cmd_fsm u_cmd_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid_i   (cmd_valid_i),
        .unsupported_i (unsupported),
        .halted_i      (halted_o),
        .resuming_i    (resumeack_o),
        .resumereq_i   (resumereq_i),
        .haltreq_i     (haltreq_i),
        .evt_i         (evt),
        .go_o          (go),
        .resume_o      (resume),
        .busy_o        (cmdbusy_o),
        .err_valid_o   (cmderror_valid_o),
        .err_o         (cmderror_o)
    );

    abst_cmd_gen u_abst_cmd_gen (
        .cmd_i         (cmd_i),
        .words_o       (words),
        .unsupported_o (unsupported)
    );

    hart_bus #(
        .PROG_BUF_SIZE (PROG_BUF_SIZE)
    ) u_hart_bus (
        .clk          (clk),
        .rst_n        (rst_n),
        .hart_i       (hart_i),
        .progbuf_i    (progbuf_i),
        .data_i       (data_i),
        .words_i      (words),
        .go_i         (go),
        .resume_i     (resume),
        .busy_i       (cmdbusy_o),
        .cmd_i        (cmd_i),
        .evt_o        (evt),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .gnt_o        (gnt_o),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_dbg_mem.sv ====
// Random testbench for the hart-facing debug memory.
// Plays the hart on the bus and the debugger on the command port, and checks
// the responses against a model of the status flags and the abstract words.
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_mem import dbg_map_pkg::*, dbg_cmd_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int PB_SIZE    = 7;
    localparam int DATA_ITERS = 40;
    localparam int ERR_ITERS  = 12;
    localparam int CMD_ITERS  = 24;
    localparam int BUSY_LIMIT = 20;
    // summed cycle budget of all tests
    localparam int TEST_CYCLES = 20 + DATA_ITERS * 3 + 20 + ERR_ITERS * 8 + 10 +
                                 CMD_ITERS * 60 + 10;
    localparam int WATCHDOG_NS = 4 * TEST_CYCLES * CLK_PERIOD;

    logic             clk;
    logic             rst_n;
    logic             clear_resumeack_i;
    logic             resumereq_i;
    logic             haltreq_i;
    logic             ndmreset_i;
    logic [9:0][31:0] progbuf_i;
    logic [31:0]      data_i;
    logic             cmd_valid_i;
    cmd_t             cmd_i;
    hart_req_t        hart_i;
    logic             halted_o;
    logic             resumeack_o;
    logic [31:0]      data_o;
    logic             data_valid_o;
    logic             cmderror_valid_o;
    cmd_err_t         cmderror_o;
    logic             cmdbusy_o;
    logic             gnt_o;
    logic             rvalid_o;
    logic [31:0]      rdata_o;

    // values seen in the cycle of a write or a command
    logic [31:0] wr_data;
    logic        wr_data_valid;
    logic        wr_err_valid;
    cmd_err_t    wr_err;
    logic        cmd_err_valid;
    cmd_err_t    cmd_err;

    // model state
    logic m_halted;
    logic m_resumeack;
    logic m_busy;

    int    test_num;
    int    tests_failed;
    int    cur_errors;
    string cur_name;

    dbg_mem_top #(
        .PROG_BUF_SIZE (PB_SIZE)
    ) DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .clear_resumeack_i (clear_resumeack_i),
        .resumereq_i       (resumereq_i),
        .haltreq_i         (haltreq_i),
        .ndmreset_i        (ndmreset_i),
        .progbuf_i         (progbuf_i),
        .data_i            (data_i),
        .cmd_valid_i       (cmd_valid_i),
        .cmd_i             (cmd_i),
        .hart_i            (hart_i),
        .halted_o          (halted_o),
        .resumeack_o       (resumeack_o),
        .data_o            (data_o),
        .data_valid_o      (data_valid_o),
        .cmderror_valid_o  (cmderror_valid_o),
        .cmderror_o        (cmderror_o),
        .cmdbusy_o         (cmdbusy_o),
        .gnt_o             (gnt_o),
        .rvalid_o          (rvalid_o),
        .rdata_o           (rdata_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %08h, expected %08h", $time, name, got, exp);
            cur_errors++;
        end
    endtask

    task automatic check_err(input string name, input cmd_err_t got, input cmd_err_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %s (%0d), expected %s (%0d)", $time, name,
                     got.name(), got, exp.name(), exp);
            cur_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            cur_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_num++;
        cur_name   = name;
        cur_errors = 0;
    endtask

    task automatic end_test();
        if (cur_errors == 0) begin
            $display("test %0d %s: ok", test_num, cur_name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, cur_name, cur_errors);
            tests_failed++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_status();
        @(negedge clk);
        check_bit("halted_o", halted_o, m_halted);
        check_bit("resumeack_o", resumeack_o, m_resumeack);
        check_bit("cmdbusy_o", cmdbusy_o, m_busy);
        next_cycle();
    endtask

    task automatic bus_write(input logic [11:0] a, input logic [3:0] be, input logic [31:0] wd);
        hart_i       = '0;
        hart_i.req   = 1'b1;
        hart_i.we    = 1'b1;
        hart_i.addr  = {20'd0, a};
        hart_i.be    = be;
        hart_i.wdata = wd;
        @(negedge clk);
        check_bit("gnt_o", gnt_o, 1'b1);
        wr_data       = data_o;
        wr_data_valid = data_valid_o;
        wr_err_valid  = cmderror_valid_o;
        wr_err        = cmderror_o;
        next_cycle();
        hart_i = '0;
    endtask

    task automatic bus_read(input logic [11:0] a, output logic [31:0] rd);
        hart_i      = '0;
        hart_i.req  = 1'b1;
        hart_i.addr = {20'd0, a};
        @(negedge clk);
        check_bit("gnt_o", gnt_o, 1'b1);
        next_cycle();
        hart_i = '0;
        @(negedge clk);
        check_bit("rvalid_o", rvalid_o, 1'b1);
        rd = rdata_o;
        next_cycle();
    endtask

    // the DUT keeps reading cmd_i while busy so it stays on the port after the pulse
    task automatic send_cmd(input cmd_t c);
        cmd_i       = c;
        cmd_valid_i = 1'b1;
        @(negedge clk);
        cmd_err_valid = cmderror_valid_o;
        cmd_err       = cmderror_o;
        next_cycle();
        cmd_valid_i = 1'b0;
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        @(negedge clk);
        while (cmdbusy_o && n < BUSY_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cmdbusy_o) begin
            $display("at %0d ns cmdbusy_o did not fall within %0d cycles", $time, BUSY_LIMIT);
            cur_errors++;
        end
        next_cycle();
    endtask

    // RV32 encodings for the model
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    // jal x0 with a byte offset
    function automatic logic [31:0] enc_j(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    // a0 is x10 and s0 is x8
    // dscratch0 and dscratch1 are 0x7b2 and 0x7b3
    function automatic cmd_words_t model_words(input cmd_t c);
        cmd_words_t  w;
        logic        gpr;
        logic [4:0]  r;
        logic [11:0] csr;
        gpr  = (c.regno[15:12] == 4'h1);
        r    = c.regno[4:0];
        csr  = gpr ? 12'h7b3 : c.regno[11:0];
        w[0] = enc_i(12'h7b3, 5'd10, 3'd1, 5'd0, 7'h73);
        w[1] = {20'd0, 5'd10, 7'h17};
        w[2] = enc_i(12'd12, 5'd10, 3'd5, 5'd10, 7'h13);
        w[3] = enc_i(12'd12, 5'd10, 3'd1, 5'd10, 7'h13);
        for (int i = 4; i < 8; i++) begin
            w[i] = 32'h0000_0013;
        end
        w[8] = enc_i(12'h7b3, 5'd0, 3'd2, 5'd10, 7'h73);
        w[9] = c.postexec ? 32'h0000_0013 : 32'h0010_0073;
        if (c.transfer) begin
            if (gpr && r != 5'd10) begin
                w[4] = c.write ? enc_i(12'h380, 5'd10, c.aarsize, r, 7'h03) :
                                 enc_s(12'h380, r, 5'd10, c.aarsize);
            end else begin
                w[4] = enc_i(12'h7b2, 5'd8, 3'd1, 5'd0, 7'h73);
                w[5] = c.write ? enc_i(12'h380, 5'd10, c.aarsize, 5'd8, 7'h03) :
                                 enc_i(csr, 5'd0, 3'd2, 5'd8, 7'h73);
                w[6] = c.write ? enc_i(csr, 5'd8, 3'd1, 5'd0, 7'h73) :
                                 enc_s(12'h380, 5'd8, 5'd10, c.aarsize);
                w[7] = enc_i(12'h7b2, 5'd0, 3'd2, 5'd8, 7'h73);
            end
        end
        return w;
    endfunction

    function automatic cmd_t rand_legal_cmd();
        cmd_t c;
        c          = '0;
        c.cmd_type = CMD_ACCESS_REG;
        c.aarsize  = 3'($urandom_range(0, 2));
        c.postexec = 1'($urandom);
        c.transfer = 1'($urandom);
        c.write    = 1'($urandom);
        case ($urandom_range(0, 2))
            0: c.regno = 16'h1000 + 16'($urandom_range(0, 31));
            1: c.regno = 16'h100a;
            default: c.regno = {4'h0, 12'($urandom)};
        endcase
        return c;
    endfunction

    function automatic cmd_t rand_unsupported_cmd();
        cmd_t c;
        c = rand_legal_cmd();
        case ($urandom_range(0, 3))
            0: c.cmd_type = 8'($urandom_range(1, 255));
            1: c.aarsize = 3'($urandom_range(3, 7));
            2: c.postincrement = 1'b1;
            default: c.regno = 16'($urandom_range(32'h1020, 32'hffff));
        endcase
        return c;
    endfunction

    initial begin
        cmd_t        c;
        cmd_words_t  exp_words;
        logic [31:0] rd;
        logic [31:0] wd;
        logic [31:0] exp;
        logic [3:0]  be;
        logic [11:0] a;
        logic [20:0] off;

        void'($urandom(32'hccf36046));
        rst_n             = 1'b0;
        clear_resumeack_i = 1'b0;
        resumereq_i       = 1'b0;
        haltreq_i         = 1'b0;
        ndmreset_i        = 1'b0;
        data_i            = '0;
        cmd_valid_i       = 1'b0;
        cmd_i             = '0;
        hart_i            = '0;
        for (int i = 0; i < 10; i++) begin
            progbuf_i[i] = $urandom;
        end
        m_halted     = 1'b0;
        m_resumeack  = 1'b0;
        m_busy       = 1'b0;
        test_num     = 0;
        tests_failed = 0;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("reset_values");
        @(negedge clk);
        check_bit("cmderror_valid_o", cmderror_valid_o, 1'b0);
        check_bit("rvalid_o", rvalid_o, 1'b0);
        check_bit("data_valid_o", data_valid_o, 1'b0);
        check_word("rdata_o", rdata_o, 32'd0);
        next_cycle();
        check_status();
        end_test();

        begin_test("data_access");
        for (int n = 0; n < DATA_ITERS; n++) begin
            a      = DATA_BASE + 12'(4 * $urandom_range(0, DATA_WORDS - 1));
            be     = 4'($urandom);
            wd     = $urandom;
            data_i = $urandom;
            exp    = data_i;
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    exp[8*b +: 8] = wd[8*b +: 8];
                end
            end
            bus_write(a, be, wd);
            check_bit("data_valid_o", wr_data_valid, 1'b1);
            check_word("data_o", wr_data, exp);
            data_i = $urandom;
            bus_read(a, rd);
            check_word("rdata_o", rd, data_i);
        end
        end_test();

        begin_test("halt_resume");
        bus_write(HALTED_ADDR, 4'hf, 32'd0);
        m_halted = 1'b1;
        check_status();
        resumereq_i = 1'b1;
        next_cycle();
        m_busy = 1'b1;
        check_status();
        bus_read(FLAGS_ADDR, rd);
        check_word("flags", rd, 32'd2);
        resumereq_i = 1'b0;
        bus_write(RESUMING_ADDR, 4'hf, 32'd0);
        next_cycle();
        m_halted    = 1'b0;
        m_resumeack = 1'b1;
        m_busy      = 1'b0;
        check_status();
        clear_resumeack_i = 1'b1;
        next_cycle();
        clear_resumeack_i = 1'b0;
        m_resumeack       = 1'b0;
        check_status();
        end_test();

        begin_test("command_errors");
        for (int n = 0; n < ERR_ITERS; n++) begin
            send_cmd(cmd_t'($urandom));
            check_bit("cmderror_valid_o", cmd_err_valid, 1'b1);
            check_err("cmderror_o", cmd_err, HALT_RESUME);
            check_status();
        end
        bus_write(HALTED_ADDR, 4'hf, 32'd0);
        m_halted = 1'b1;
        for (int n = 0; n < ERR_ITERS; n++) begin
            send_cmd(rand_unsupported_cmd());
            check_bit("cmderror_valid_o", cmd_err_valid, 1'b1);
            check_err("cmderror_o", cmd_err, NOT_SUPPORTED);
            check_status();
        end
        end_test();

        begin_test("access_register");
        for (int n = 0; n < CMD_ITERS; n++) begin
            c         = rand_legal_cmd();
            exp_words = model_words(c);
            send_cmd(c);
            check_bit("cmderror_valid_o", cmd_err_valid, 1'b0);
            m_busy = 1'b1;
            check_status();
            bus_read(FLAGS_ADDR, rd);
            check_word("flags", rd, 32'd1);
            off = c.postexec ? 21'(PROGBUF_BASE - WHERETO_ADDR) :
                               21'(ABST_CMD_BASE - WHERETO_ADDR);
            bus_read(WHERETO_ADDR, rd);
            check_word("whereto", rd, enc_j(off));
            for (int i = 0; i < 10; i++) begin
                bus_read(ABST_CMD_BASE + 12'(4 * i), rd);
                check_word($sformatf("abst_cmd[%0d]", i), rd, exp_words[i]);
            end
            for (int i = 0; i < 10; i++) begin
                bus_read(PROGBUF_BASE + 12'(4 * i), rd);
                exp = (i < PB_SIZE) ? progbuf_i[i] : 32'd0;
                check_word($sformatf("progbuf[%0d]", i), rd, exp);
            end
            bus_write(GOING_ADDR, 4'hf, $urandom);
            repeat ($urandom_range(0, 4)) next_cycle();
            bus_write(HALTED_ADDR, 4'hf, $urandom);
            m_busy = 1'b0;
            wait_not_busy();
            check_status();
        end
        end_test();

        begin_test("exception");
        bus_write(EXCEPTION_ADDR, 4'hf, 32'd0);
        check_bit("cmderror_valid_o", wr_err_valid, 1'b1);
        check_err("cmderror_o", wr_err, EXCEPTION);
        check_status();
        end_test();

        $display("summary: %0d run, %0d passed, %0d failed", test_num,
                 test_num - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/dbg_map_pkg.sv
common/dbg_cmd_pkg.sv
dbg_cmd/abst_cmd_gen.sv
dbg_cmd/cmd_fsm.sv
logic/hart_status.sv
logic/hart_bus.sv
logic/dbg_mem_top.sv
tests/tb_dbg_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dbg_mem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
FAIL_MSG  ?= tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
